/* src/scc_defines.svh */
/*
 * Wavetable sound generator constants
 * Channel count, waveform depth, output period and bus region codes
 */
`ifndef SCC_DEFINES_SVH
`define SCC_DEFINES_SVH

`define SCC_NUM_CH        5     // Sound channels
`define SCC_WAVE_DEPTH    32    // Samples per waveform
`define SCC_OUT_PERIOD    16    // clk_en ticks per output sample

// Address regions, taken from addr[7:5]
`define SCC_REG_REGION    4     // Frequency, volume and enable registers
`define SCC_CH4_WR_REGION 3     // Writes here also land in channel 4
`define SCC_CH4_RD_REGION 5     // Channel 4 readback window

`endif

/* src/scc_bus_pkg.sv */
/*
 * Wavetable sound generator bus types
 * Address, data byte and address region of the CPU side
 */
`default_nettype none

package scc_bus_pkg;

    // CPU address, region in the top three bits
    typedef logic [7:0] addr_t;

    // Bus data byte
    typedef logic [7:0] data_t;

    // Region code, addr[7:5]
    typedef logic [2:0] region_t;

endpackage

`default_nettype wire

/* src/scc_audio_pkg.sv */
/*
 * Wavetable sound generator audio types
 * Sample, volume, divider, index, accumulator and mix widths
 */
`default_nettype none

`include "scc_defines.svh"

package scc_audio_pkg;

    typedef logic signed [7:0]  sample_t;    // Two's complement waveform sample
    typedef logic [3:0]         vol_t;       // Volume, 0 is silent
    typedef logic [11:0]        freq_t;      // Divider, period is freq+1 ticks

    // Playback position inside a waveform
    typedef logic [$clog2(`SCC_WAVE_DEPTH)-1:0] wave_idx_t;

    typedef logic signed [11:0] acc_t;       // Repeated-addition scaler
    typedef logic signed [10:0] mix_t;       // Sum of all channels

endpackage

`default_nettype wire

/* src/scc_bus_ctrl.sv */
/*
 * Bus controller of the sound generator
 * Write edge detect, address decode, enable register, readback merge
 * and the output period tick
 */
`timescale 1ns/1ps
`default_nettype none

`include "scc_defines.svh"

module scc_bus_ctrl (
    input  wire                     CLK,
    input  wire                     RESET_n,
    input  wire                     clk_en,
    input  wire                     cs_n,
    input  wire                     wr_n,
    input  wire                     rd_n,
    input  wire scc_bus_pkg::addr_t addr,
    input  wire scc_bus_pkg::data_t din,
    input  wire scc_bus_pkg::data_t ram_rdata [`SCC_NUM_CH],
    output logic [`SCC_NUM_CH-1:0]  wr_freq_lo,
    output logic [`SCC_NUM_CH-1:0]  wr_freq_hi,
    output logic [`SCC_NUM_CH-1:0]  wr_vol,
    output logic [`SCC_NUM_CH-1:0]  wr_wave,
    output logic [`SCC_NUM_CH-1:0]  rd_wave,
    output logic [`SCC_NUM_CH-1:0]  mute_n,
    output logic                    sample_tick,
    output scc_bus_pkg::data_t      dout,
    output logic                    busdir_n
);

    localparam int CNT_W = $clog2(`SCC_OUT_PERIOD);

    scc_bus_pkg::region_t   region;
    logic [3:0]             offset;            // Register offset within region 4
    logic                   wr_act;            // Chip selected and write low
    logic                   rd_act;
    logic                   wr_held;           // Write seen at the previous edge
    logic                   wr_start;          // First sampled cycle of a write
    logic [`SCC_NUM_CH-1:0] freq_lo_d;
    logic [`SCC_NUM_CH-1:0] freq_hi_d;
    logic [`SCC_NUM_CH-1:0] vol_d;
    logic [`SCC_NUM_CH-1:0] wave_d;
    logic                   en_d;
    logic                   en_stb;
    logic [`SCC_NUM_CH-1:0] enable_reg;        // Bit k unmutes channel k
    logic [CNT_W-1:0]       period_cnt;

    assign region   = addr[7:5];
    assign offset   = addr[3:0];
    assign wr_act   = !cs_n && !wr_n;
    assign rd_act   = !cs_n && !rd_n && wr_n;  // Write wins if both are low
    assign wr_start = wr_act && !wr_held;

    // Decode, channel 4 has its own write and read regions
    always_comb begin
        freq_lo_d = '0;
        freq_hi_d = '0;
        vol_d     = '0;
        wave_d    = '0;
        rd_wave   = '0;
        en_d      = wr_start && (region == 3'(`SCC_REG_REGION)) && (offset == 4'd15);
        for (int k = 0; k < `SCC_NUM_CH; k++) begin
            if (wr_start && (region == 3'(`SCC_REG_REGION))) begin
                freq_lo_d[k] = (offset == 4'(2 * k));
                freq_hi_d[k] = (offset == 4'(2 * k + 1));
                vol_d[k]     = (offset == 4'(10 + k));
            end
            if (k == `SCC_NUM_CH - 1) begin
                wave_d[k]  = wr_start && (region == 3'(`SCC_CH4_WR_REGION));
                rd_wave[k] = rd_act && (region == 3'(`SCC_CH4_RD_REGION));
            end else begin
                wave_d[k]  = wr_start && (region == 3'(k));
                rd_wave[k] = rd_act && (region == 3'(k));
            end
        end
    end

    // Strobes fire one cycle after the write is sampled
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wr_held    <= 1'b0;
            wr_freq_lo <= '0;
            wr_freq_hi <= '0;
            wr_vol     <= '0;
            wr_wave    <= '0;
            en_stb     <= 1'b0;
        end else begin
            wr_held    <= wr_act;              // Holding wr_n low gives one write
            wr_freq_lo <= freq_lo_d;
            wr_freq_hi <= freq_hi_d;
            wr_vol     <= vol_d;
            wr_wave    <= wave_d;
            en_stb     <= en_d;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            enable_reg <= '0;
        end else if (en_stb) begin
            enable_reg <= din[`SCC_NUM_CH-1:0];
        end
    end

    assign mute_n = enable_reg;

    // Output period, first tick of each period is the sample tick
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            period_cnt <= '0;
        end else if (clk_en) begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign sample_tick = clk_en && (period_cnt == '0);

    // Readback, lines up with the registered RAM data
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            busdir_n <= 1'b1;
        end else begin
            busdir_n <= !(|rd_wave);
        end
    end

    always_comb begin
        dout = '0;
        for (int k = 0; k < `SCC_NUM_CH; k++) begin
            dout = dout | ram_rdata[k];        // Idle RAMs return zero
        end
    end

    a_freq_lo_onehot: assert property (@(posedge CLK) disable iff (!RESET_n)
        $onehot0(wr_freq_lo))
        else $error("more than one frequency low strobe");

    a_wr_rd_excl: assert property (@(posedge CLK) disable iff (!RESET_n)
        !((|wr_wave) && (|rd_wave)))
        else $error("waveform write and read in the same cycle");

endmodule

`default_nettype wire

/* src/scc_tone_counter.sv */
/*
 * Channel tone counter
 * Frequency register and reloading down counter stepping the waveform index
 */
`timescale 1ns/1ps
`default_nettype none

module scc_tone_counter (
    input  wire                     CLK,
    input  wire                     RESET_n,
    input  wire                     clk_en,
    input  wire                     wr_freq_lo,
    input  wire                     wr_freq_hi,
    input  wire scc_bus_pkg::data_t din,
    output scc_audio_pkg::wave_idx_t wave_idx
);

    scc_audio_pkg::freq_t freq;    // Divider, reload value
    scc_audio_pkg::freq_t cnt;     // Ticks left until the next step

    // Low byte and high nibble are written separately
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            freq <= '0;
        end else if (wr_freq_lo) begin
            freq[7:0] <= din;
        end else if (wr_freq_hi) begin
            freq[11:8] <= din[3:0];      // Upper bits of the byte ignored
        end
    end

    // Reload at zero, so one step every freq+1 ticks
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            cnt      <= '0;
            wave_idx <= '0;
        end else if (clk_en) begin
            if (cnt == '0) begin
                cnt      <= freq;
                wave_idx <= wave_idx + 1'b1;     // Wraps at the waveform end
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/scc_wave_ram.sv */
/*
 * Channel waveform memory
 * 32 bytes, bus write and readback port plus a playback port
 */
`timescale 1ns/1ps
`default_nettype none

`include "scc_defines.svh"

module scc_wave_ram (
    input  wire                          CLK,
    input  wire                          RESET_n,
    input  wire                          wr_wave,
    input  wire                          rd_wave,
    input  wire scc_audio_pkg::wave_idx_t bus_idx,
    input  wire scc_bus_pkg::data_t      din,
    input  wire scc_audio_pkg::wave_idx_t wave_idx,
    output scc_bus_pkg::data_t           rdata,
    output scc_audio_pkg::sample_t       wave_data
);

    scc_bus_pkg::data_t mem [`SCC_WAVE_DEPTH];

    always_ff @(posedge CLK) begin
        if (wr_wave) begin
            mem[bus_idx] <= din;
        end
    end

    // Bus side, zero when not addressed so the controller can OR
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            rdata <= '0;
        end else if (rd_wave) begin
            rdata <= mem[bus_idx];
        end else begin
            rdata <= '0;
        end
    end

    // Playback fetch every cycle
    always_ff @(posedge CLK) begin
        wave_data <= scc_audio_pkg::sample_t'(mem[wave_idx]);
    end

    a_rdata_idle: assert property (@(posedge CLK) disable iff (!RESET_n)
        !$past(rd_wave) |-> (rdata == '0))
        else $error("read data driven without a read");

endmodule

`default_nettype wire

/* src/scc_amp.sv */
/*
 * Channel amplifier
 * Volume register, scaling by repeated addition over one output period,
 * and mute
 */
`timescale 1ns/1ps
`default_nettype none

module scc_amp (
    input  wire                          CLK,
    input  wire                          RESET_n,
    input  wire                          clk_en,
    input  wire                          sample_tick,
    input  wire                          wr_vol,
    input  wire                          mute_n,
    input  wire scc_bus_pkg::data_t      din,
    input  wire scc_audio_pkg::sample_t  wave_data,
    output scc_audio_pkg::sample_t       ch_out
);

    scc_audio_pkg::vol_t vol;
    scc_audio_pkg::vol_t remain;     // Additions still due this period
    scc_audio_pkg::acc_t acc;
    scc_audio_pkg::acc_t sample_ext;

    assign sample_ext = scc_audio_pkg::acc_t'(wave_data);  // Sign extended

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            vol <= '0;
        end else if (wr_vol) begin
            vol <= din[3:0];
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            ch_out <= '0;
            remain <= '0;
            acc    <= '0;
        end else if (sample_tick) begin
            // Publish last period, top 8 of 12 bits
            ch_out <= mute_n ? scc_audio_pkg::sample_t'(acc[11:4]) : '0;
            if (vol != '0) begin
                acc    <= sample_ext;      // First addition
                remain <= vol - 1'b1;
            end else begin
                acc    <= '0;
                remain <= '0;
            end
        end else if (clk_en && (remain != '0)) begin
            acc    <= acc + sample_ext;
            remain <= remain - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/scc_mixer.sv */
/*
 * Channel mixer
 * Sign-extends each channel and sums them once per output period
 */
`timescale 1ns/1ps
`default_nettype none

`include "scc_defines.svh"

module scc_mixer (
    input  wire                          CLK,
    input  wire                          RESET_n,
    input  wire                          sample_tick,
    input  wire scc_audio_pkg::sample_t  ch_in [`SCC_NUM_CH],
    output scc_audio_pkg::mix_t          out
);

    scc_audio_pkg::mix_t ch_ext [`SCC_NUM_CH];   // Captured, widened inputs
    scc_audio_pkg::mix_t sum;

    always_comb begin
        sum = '0;
        for (int k = 0; k < `SCC_NUM_CH; k++) begin
            sum = sum + ch_ext[k];
        end
    end

    // Sum lags the capture by one period
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            out <= '0;
            for (int k = 0; k < `SCC_NUM_CH; k++) begin
                ch_ext[k] <= '0;
            end
        end else if (sample_tick) begin
            out <= sum;
            for (int k = 0; k < `SCC_NUM_CH; k++) begin
                ch_ext[k] <= scc_audio_pkg::mix_t'(ch_in[k]);
            end
        end
    end

endmodule

`default_nettype wire

/* src/scc_top.sv */
/*
 * Five channel wavetable sound generator
 * Bus controller, per-channel counter, waveform RAM and amplifier, mixer
 */
`timescale 1ns/1ps
`default_nettype none

`include "scc_defines.svh"

module scc_top (
    input  wire                     CLK,
    input  wire                     RESET_n,
    input  wire                     clk_en,
    input  wire                     cs_n,
    input  wire                     wr_n,
    input  wire                     rd_n,
    input  wire scc_bus_pkg::addr_t addr,
    input  wire scc_bus_pkg::data_t din,
    output scc_bus_pkg::data_t      dout,
    output logic                    busdir_n,
    output scc_audio_pkg::mix_t     out
);

    logic [`SCC_NUM_CH-1:0]   wr_freq_lo;
    logic [`SCC_NUM_CH-1:0]   wr_freq_hi;
    logic [`SCC_NUM_CH-1:0]   wr_vol;
    logic [`SCC_NUM_CH-1:0]   wr_wave;
    logic [`SCC_NUM_CH-1:0]   rd_wave;
    logic [`SCC_NUM_CH-1:0]   mute_n;
    logic                     sample_tick;
    scc_bus_pkg::data_t       ram_rdata [`SCC_NUM_CH];
    scc_audio_pkg::wave_idx_t wave_idx  [`SCC_NUM_CH];
    scc_audio_pkg::sample_t   wave_data [`SCC_NUM_CH];
    scc_audio_pkg::sample_t   ch_out    [`SCC_NUM_CH];

    scc_bus_ctrl scc_bus_ctrl_inst (
        .CLK        (CLK),
        .RESET_n    (RESET_n),
        .clk_en     (clk_en),
        .cs_n       (cs_n),
        .wr_n       (wr_n),
        .rd_n       (rd_n),
        .addr       (addr),
        .din        (din),
        .ram_rdata  (ram_rdata),
        .wr_freq_lo (wr_freq_lo),
        .wr_freq_hi (wr_freq_hi),
        .wr_vol     (wr_vol),
        .wr_wave    (wr_wave),
        .rd_wave    (rd_wave),
        .mute_n     (mute_n),
        .sample_tick(sample_tick),
        .dout       (dout),
        .busdir_n   (busdir_n)
    );

    // One datapath per channel
    for (genvar ch = 0; ch < `SCC_NUM_CH; ch++) begin : g_ch
        scc_tone_counter scc_tone_counter_inst (
            .CLK       (CLK),
            .RESET_n   (RESET_n),
            .clk_en    (clk_en),
            .wr_freq_lo(wr_freq_lo[ch]),
            .wr_freq_hi(wr_freq_hi[ch]),
            .din       (din),
            .wave_idx  (wave_idx[ch])
        );

        scc_wave_ram scc_wave_ram_inst (
            .CLK      (CLK),
            .RESET_n  (RESET_n),
            .wr_wave  (wr_wave[ch]),
            .rd_wave  (rd_wave[ch]),
            .bus_idx  (addr[4:0]),     // Entry within the region
            .din      (din),
            .wave_idx (wave_idx[ch]),
            .rdata    (ram_rdata[ch]),
            .wave_data(wave_data[ch])
        );

        scc_amp scc_amp_inst (
            .CLK        (CLK),
            .RESET_n    (RESET_n),
            .clk_en     (clk_en),
            .sample_tick(sample_tick),
            .wr_vol     (wr_vol[ch]),
            .mute_n     (mute_n[ch]),
            .din        (din),
            .wave_data  (wave_data[ch]),
            .ch_out     (ch_out[ch])
        );
    end

    scc_mixer scc_mixer_inst (
        .CLK        (CLK),
        .RESET_n    (RESET_n),
        .sample_tick(sample_tick),
        .ch_in      (ch_out),
        .out        (out)
    );

endmodule

`default_nettype wire

/* dv/scc_tb.sv */
/*
 * Testbench for the five channel wavetable sound generator
 * Table of bus writes, readback checks and output level checks against a model
 */
`timescale 1ns/1ps
`default_nettype none

`include "scc_defines.svh"

module scc_tb;

    localparam int CLK_PERIOD = 100;                      // ns
    localparam int SETTLE_CYC = 4 * `SCC_OUT_PERIOD + 2;  // Four output periods plus margin
    localparam int STEP_CYC   = `SCC_WAVE_DEPTH * 4;      // Full waveform at divider 3
    localparam int HALF_CYC   = `SCC_WAVE_DEPTH / 2 * 4;  // One half of the waveform
    localparam int NUM_TESTS  = 6;

    // Row kinds
    localparam int OP_WR     = 0;
    localparam int OP_RD     = 1;    // Read and compare dout
    localparam int OP_SETTLE = 2;    // Wait four periods, compare out
    localparam int OP_STEP   = 3;    // Watch out over a whole waveform

    logic                CLK = 1'b0;
    logic                RESET_n;
    logic                clk_en;
    logic                cs_n;
    logic                wr_n;
    logic                rd_n;
    scc_bus_pkg::addr_t  addr;
    scc_bus_pkg::data_t  din;
    scc_bus_pkg::data_t  dout;
    logic                busdir_n;
    scc_audio_pkg::mix_t out;

    // Stimulus table, one element per row in each queue
    int                 row_op   [$];
    int                 row_test [$];
    logic [7:0]         row_addr [$];
    logic [7:0]         row_data [$];
    logic signed [10:0] row_exp  [$];

    string test_names [NUM_TESTS] = '{"reset state", "waveform readback",
        "channel 4 sharing", "constant-wave level", "muting and mixing",
        "frequency stepping"};

    int              test_errs;
    int              total_errs;
    int              checks;
    int              tests_run;
    bit              table_ready = 1'b0;
    longint unsigned wd_limit_ns;

    scc_top scc_top_inst (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .clk_en  (clk_en),
        .cs_n    (cs_n),
        .wr_n    (wr_n),
        .rd_n    (rd_n),
        .addr    (addr),
        .din     (din),
        .dout    (dout),
        .busdir_n(busdir_n),
        .out     (out)
    );

    initial begin
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Model of one channel: top 8 of volume times sample, zero when muted
    function automatic logic signed [10:0] contrib(input logic [3:0] vol,
                                                   input logic [7:0] s, input logic en);
        logic signed [11:0] prod;
        logic [7:0]         top;
        prod = $signed({1'b0, vol}) * $signed(s);
        top  = prod[11:4];
        return en ? {{3{top[7]}}, top} : 11'sd0;
    endfunction

    function automatic logic [7:0] wave_addr(input int region, input int idx);
        return {3'(region), 5'(idx)};
    endfunction

    function automatic logic [7:0] reg_addr(input int offset);
        return {3'(`SCC_REG_REGION), 5'(offset)};
    endfunction

    task automatic add_row(input int op, input int test, input logic [7:0] a,
                           input logic [7:0] d, input logic signed [10:0] want);
        row_op.push_back(op);
        row_test.push_back(test);
        row_addr.push_back(a);
        row_data.push_back(d);
        row_exp.push_back(want);
    endtask

    task automatic fill_wave(input int test, input int region, input logic [7:0] v);
        for (int i = 0; i < `SCC_WAVE_DEPTH; i++) begin
            add_row(OP_WR, test, wave_addr(region, i), v, 11'sd0);
        end
    endtask

    task automatic build_table();
        logic [7:0]         wave_val [4][`SCC_WAVE_DEPTH];
        logic [7:0]         v   [`SCC_NUM_CH];    // Constant level per channel
        logic [3:0]         vol [`SCC_NUM_CH];
        logic signed [10:0] c   [`SCC_NUM_CH];    // Model contribution when enabled
        logic [7:0]         b;
        logic [7:0]         p;
        add_row(OP_SETTLE, 1, 8'h00, 8'h00, 11'sd0);        // Idle after reset
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < `SCC_WAVE_DEPTH; i++) begin
                wave_val[r][i] = 8'($urandom);
                add_row(OP_WR, 2, wave_addr(r, i), wave_val[r][i], 11'sd0);
            end
        end
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < `SCC_WAVE_DEPTH; i++) begin
                add_row(OP_RD, 2, wave_addr(r, i), 8'h00, {3'b000, wave_val[r][i]});
            end
        end
        for (int i = 8; i < 12; i++) begin                  // Region 3 lands in both
            b = 8'($urandom);
            add_row(OP_WR, 3, wave_addr(`SCC_CH4_WR_REGION, i), b, 11'sd0);
            add_row(OP_RD, 3, wave_addr(`SCC_CH4_WR_REGION, i), 8'h00, {3'b000, b});
            add_row(OP_RD, 3, wave_addr(`SCC_CH4_RD_REGION, i), 8'h00, {3'b000, b});
        end
        for (int ch = 0; ch < `SCC_NUM_CH; ch++) begin
            v[ch]   = 8'(16 + $urandom % 224);              // Magnitude 16 or more, never silent
            vol[ch] = 4'(1 + $urandom % 15);
        end
        v[4] = v[3];                                        // Shared write region
        for (int ch = 0; ch < `SCC_NUM_CH; ch++) begin
            c[ch] = contrib(vol[ch], v[ch], 1'b1);
        end
        fill_wave(4, 0, v[0]);
        add_row(OP_WR, 4, reg_addr(10), {4'h0, vol[0]}, 11'sd0);
        add_row(OP_WR, 4, reg_addr(15), 8'h01, 11'sd0);
        add_row(OP_SETTLE, 4, 8'h00, 8'h00, c[0]);
        fill_wave(5, 1, v[1]);
        fill_wave(5, 2, v[2]);
        fill_wave(5, 3, v[3]);
        for (int ch = 1; ch < `SCC_NUM_CH; ch++) begin
            add_row(OP_WR, 5, reg_addr(10 + ch), {4'h0, vol[ch]}, 11'sd0);
        end
        add_row(OP_WR, 5, reg_addr(15), 8'h07, 11'sd0);
        add_row(OP_SETTLE, 5, 8'h00, 8'h00, c[0] + c[1] + c[2]);
        add_row(OP_WR, 5, reg_addr(15), 8'h05, 11'sd0);     // Channel 1 muted
        add_row(OP_SETTLE, 5, 8'h00, 8'h00, c[0] + c[2]);
        add_row(OP_WR, 5, reg_addr(10), 8'h00, 11'sd0);     // Channel 0 at volume 0
        add_row(OP_SETTLE, 5, 8'h00, 8'h00, c[2]);
        add_row(OP_WR, 5, reg_addr(15), 8'h1f, 11'sd0);
        add_row(OP_SETTLE, 5, 8'h00, 8'h00, c[1] + c[2] + c[3] + c[4]);
        add_row(OP_WR, 5, reg_addr(15), 8'h00, 11'sd0);
        add_row(OP_SETTLE, 5, 8'h00, 8'h00, 11'sd0);
        p = 8'(16 + $urandom % 112);                        // Nonzero at volume 1
        for (int i = 0; i < `SCC_WAVE_DEPTH; i++) begin
            add_row(OP_WR, 6, wave_addr(1, i), (i < 16) ? p : (~p + 8'd1), 11'sd0);
        end
        add_row(OP_WR, 6, reg_addr(2), 8'h03, 11'sd0);      // Divider 3
        add_row(OP_WR, 6, reg_addr(3), 8'hf0, 11'sd0);      // Upper nibble ignored
        add_row(OP_WR, 6, reg_addr(11), 8'h01, 11'sd0);
        add_row(OP_WR, 6, reg_addr(15), 8'h02, 11'sd0);
        add_row(OP_STEP, 6, 8'h00, p, 11'sd0);
    endtask

    // Bus tasks start and end just after a falling edge
    task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
        addr = a;
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        repeat (2) @(negedge CLK);
        cs_n = 1'b1;
        wr_n = 1'b1;
        @(negedge CLK);
    endtask

    task automatic bus_read_check(input logic [7:0] a, input logic [7:0] want);
        addr = a;
        cs_n = 1'b0;
        rd_n = 1'b0;
        @(negedge CLK);                                     // Data one clock after sampling
        checks += 3;
        assert (dout === want) else begin
            $display("FAIL %0d ns: read %02h gave %02h, expected %02h", $time, a, dout, want);
            test_errs++;
        end
        assert (busdir_n === 1'b0) else begin
            $display("FAIL %0d ns: busdir_n high during read of %02h", $time, a);
            test_errs++;
        end
        cs_n = 1'b1;
        rd_n = 1'b1;
        @(negedge CLK);
        assert (busdir_n === 1'b1) else begin
            $display("FAIL %0d ns: busdir_n still low after read of %02h", $time, a);
            test_errs++;
        end
    endtask

    task automatic settle_check(input logic signed [10:0] want);
        repeat (SETTLE_CYC) @(negedge CLK);
        checks += 3;
        assert (out === want) else begin
            $display("FAIL %0d ns: out %0d, expected %0d", $time, out, want);
            test_errs++;
        end
        assert (busdir_n === 1'b1) else begin
            $display("FAIL %0d ns: busdir_n low with the bus idle", $time);
            test_errs++;
        end
        assert (dout === 8'h00) else begin
            $display("FAIL %0d ns: dout %02h with the bus idle", $time, dout);
            test_errs++;
        end
    endtask

    task automatic step_window_check(input logic [7:0] p);
        logic signed [10:0] hi_v;
        logic signed [10:0] lo_v;
        logic signed [10:0] prev;
        bit                 seen_hi;
        bit                 seen_lo;
        int                 bad;
        int                 changes;                        // Level changes in the window
        hi_v    = contrib(4'd1, p, 1'b1);
        lo_v    = contrib(4'd1, ~p + 8'd1, 1'b1);
        seen_hi = 1'b0;
        seen_lo = 1'b0;
        bad     = 0;
        changes = 0;
        repeat (SETTLE_CYC) @(negedge CLK);
        prev = out;
        for (int t = 0; t < STEP_CYC; t++) begin
            @(negedge CLK);
            if (out === hi_v) seen_hi = 1'b1;
            else if (out === lo_v) seen_lo = 1'b1;
            else bad++;
            if (out !== prev) changes++;
            prev = out;
        end
        checks += 3;
        assert (bad == 0) else begin
            $display("FAIL %0d ns: out left {%0d, %0d} in %0d cycles", $time, hi_v, lo_v, bad);
            test_errs++;
        end
        assert (seen_hi && seen_lo) else begin
            $display("FAIL %0d ns: out did not reach both %0d and %0d", $time, hi_v, lo_v);
            test_errs++;
        end
        // Each half of the waveform lasts HALF_CYC ticks at divider 3
        assert (changes == STEP_CYC / HALF_CYC) else begin
            $display("FAIL %0d ns: out changed %0d times, expected %0d", $time, changes,
                     STEP_CYC / HALF_CYC);
            test_errs++;
        end
    endtask

    task automatic report_test(input int t);
        tests_run++;
        total_errs += test_errs;
        $display("Test %0d, %s: %s, %0d errors", t, test_names[t - 1],
                 (test_errs == 0) ? "passed" : "failed", test_errs);
        test_errs = 0;
    endtask

    initial begin
        RESET_n    = 1'b0;
        clk_en     = 1'b1;                                  // Tick every cycle
        cs_n       = 1'b1;
        wr_n       = 1'b1;
        rd_n       = 1'b1;
        addr       = '0;
        din        = '0;
        test_errs  = 0;
        total_errs = 0;
        checks     = 0;
        tests_run  = 0;
        void'($urandom(32'hfe9b_066b));
        build_table();
        table_ready = 1'b1;
        repeat (4) @(negedge CLK);
        RESET_n = 1'b1;
        for (int i = 0; i < row_op.size(); i++) begin
            case (row_op[i])
                OP_WR:     bus_write(row_addr[i], row_data[i]);
                OP_RD:     bus_read_check(row_addr[i], row_exp[i][7:0]);
                OP_SETTLE: settle_check(row_exp[i]);
                default:   step_window_check(row_data[i]);
            endcase
            if ((i == row_op.size() - 1) || (row_test[i + 1] != row_test[i])) begin
                report_test(row_test[i]);
            end
        end
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errs);
        if (total_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog, 64 output periods per table row
    initial begin
        wait (table_ready);
        wd_limit_ns = longint'(row_op.size()) * 64 * `SCC_OUT_PERIOD * CLK_PERIOD;
        #(wd_limit_ns);
        $display("Timeout: the run did not finish within %0d ns", wd_limit_ns);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/scc_bus_pkg.sv
src/scc_audio_pkg.sv
src/scc_bus_ctrl.sv
src/scc_tone_counter.sv
src/scc_wave_ram.sv
src/scc_amp.sv
src/scc_mixer.sv
src/scc_top.sv
dv/scc_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the sound generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module scc_tb -o scc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/scc_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
